/* Bender.yml */
package:
  name: dram_bridge

sources:
  - files:
      - verilog/mem_cmd_pkg.sv
      - verilog/dram_beat_pkg.sv
      - verilog/bridge_fifo.sv
      - verilog/cmd_intake.sv
      - verilog/dram_issue.sv
      - verilog/read_return.sv
      - verilog/dram_bridge_top.sv
  - target: test
    files:
      - testbench/dram_bridge_sva.sv
      - testbench/dram_bridge_tb.sv

/* build.f */
verilog/mem_cmd_pkg.sv
verilog/dram_beat_pkg.sv
verilog/bridge_fifo.sv
verilog/cmd_intake.sv
verilog/dram_issue.sv
verilog/read_return.sv
verilog/dram_bridge_top.sv
testbench/dram_bridge_sva.sv
testbench/dram_bridge_tb.sv

/* testbench/dram_bridge_sva.sv */
`timescale 1ns/1ps

module dram_bridge_sva (
    input logic                      Mem_Clk,
    input logic                      dram_reset,
    input logic                      dram_cmd_en,
    input logic                      dram_ready,
    input logic                      dram_rnw,
    input mem_cmd_pkg::mem_addr_t    dram_address,
    input dram_beat_pkg::dram_data_t dram_data_o,
    input dram_beat_pkg::dram_be_t   dram_byte_enable,
    input logic                      dram_data_valid,
    input logic                      rd_full
);

    // high between the two beats of a write
    logic wr_half;

    always_ff @(posedge Mem_Clk)
    begin
        if (dram_reset)
        begin
            wr_half <= 1'b0;
        end
        else if (dram_cmd_en && dram_ready && !dram_rnw)
        begin
            wr_half <= ~wr_half;
        end
    end

    // ----------------------------------------
    // dram port protocol
    // ----------------------------------------

    a_stall_hold: assert property (@(posedge Mem_Clk) disable iff (dram_reset)
        dram_cmd_en && !dram_ready |=> dram_cmd_en && $stable(dram_rnw) &&
        $stable(dram_address) && $stable(dram_data_o) && $stable(dram_byte_enable))
        else $error("dram outputs changed during a stall");

    a_write_second: assert property (@(posedge Mem_Clk) disable iff (dram_reset)
        dram_cmd_en && dram_ready && !dram_rnw && !wr_half
        |=> dram_cmd_en && !dram_rnw && $stable(dram_address))
        else $error("write first beat not followed by its second beat");

    a_write_held: assert property (@(posedge Mem_Clk) disable iff (dram_reset)
        wr_half |-> dram_cmd_en && !dram_rnw)
        else $error("second write beat not on the port");

    // Return queue never overflows
    a_rd_overflow: assert property (@(posedge Mem_Clk) disable iff (dram_reset)
        dram_data_valid |-> !rd_full)
        else $error("read beat strobed into a full return queue");

endmodule

bind dram_bridge_top dram_bridge_sva u_sva (
    .Mem_Clk          (Mem_Clk),
    .dram_reset       (dram_reset),
    .dram_cmd_en      (dram_cmd_en),
    .dram_ready       (dram_ready),
    .dram_rnw         (dram_rnw),
    .dram_address     (dram_address),
    .dram_data_o      (dram_data_o),
    .dram_byte_enable (dram_byte_enable),
    .dram_data_valid  (dram_data_valid),
    .rd_full          (u_read_return.u_rd_fifo.full)
);

/* testbench/dram_bridge_tb.sv */
`timescale 1ns/1ps

module dram_bridge_tb;

    localparam int ADDR_DEPTH = 16;
    localparam int DATA_DEPTH = 32;
    localparam int RD_DEPTH   = 16;
    localparam int AF_MARGIN  = 2;
    localparam int WAIT_LIMIT = 4000;

    logic                       Mem_Clk;
    logic                       dram_reset;
    logic                       mem_cmd_valid;
    logic                       mem_cmd_rnw;
    mem_cmd_pkg::mem_addr_t     mem_cmd_address;
    dram_beat_pkg::dram_data_t  mem_wr_din;
    dram_beat_pkg::dram_be_t    mem_wr_be;
    logic                       mem_cmd_ack;
    logic                       mem_rd_valid;
    dram_beat_pkg::dram_data_t  mem_rd_dout;
    logic                       mem_rd_ack;
    logic                       dram_cmd_en;
    logic                       dram_rnw;
    mem_cmd_pkg::mem_addr_t     dram_address;
    dram_beat_pkg::dram_data_t  dram_data_o;
    dram_beat_pkg::dram_be_t    dram_byte_enable;
    logic                       dram_ready;
    logic                       dram_data_valid;
    dram_beat_pkg::dram_data_t  dram_data_i;

    integer                     seed;
    integer                     pace_rnd;
    int                         mismatch_cnt;
    int                         other_cnt;
    int                         beats_pending;
    int                         ready_mode;
    int                         ret_delay;
    logic                       ack_random;
    logic                       pair_open;
    logic                       second_beat;
    logic                       hold_prev;
    logic                       rd_hold_prev;
    logic [194:0]               port_prev;
    dram_beat_pkg::dram_data_t  rd_prev;
    dram_beat_pkg::dram_data_t  first_data;

    // expected dram commands as {address, rnw}
    mem_cmd_pkg::addr_entry_t   exp_cmds[$];
    // beats as the write-data queue holds them
    dram_beat_pkg::data_entry_t beat_model[$];
    dram_beat_pkg::dram_data_t  exp_rd[$];
    dram_beat_pkg::dram_data_t  ret_q[$];
    logic [287:0]               mem_model[mem_cmd_pkg::mem_addr_t];

    dram_bridge_top #(
        .ADDR_DEPTH (ADDR_DEPTH),
        .DATA_DEPTH (DATA_DEPTH),
        .RD_DEPTH   (RD_DEPTH),
        .AF_MARGIN  (AF_MARGIN)
    ) i_dut (.*);

    always #10 Mem_Clk = ~Mem_Clk;

    // beat of a never-written address
    function automatic dram_beat_pkg::dram_data_t ref_beat(input mem_cmd_pkg::mem_addr_t addr,
                                                           input int idx);
        mem_cmd_pkg::mem_addr_t a;
        a = addr + idx;
        return {a[15:0], a, a, a, a};
    endfunction

    function automatic dram_beat_pkg::dram_data_t random_beat();
        return {$random(seed), $random(seed), $random(seed), $random(seed), 16'($random(seed))};
    endfunction

    task automatic finish_run();
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    task automatic abort_run(input string msg);
        other_cnt++;
        $display("%s", msg);
        finish_run();
    endtask

    task automatic report_mismatch(input string name, input logic [287:0] exp,
                                   input logic [287:0] got);
        mismatch_cnt++;
        $display("mismatch %s expected %0h got %0h at %0t", name, exp, got, $time);
    endtask

    // ----------------------------------------
    // dram model and comparison
    // ----------------------------------------

    task automatic queue_read_beats(input mem_cmd_pkg::mem_addr_t addr);
        dram_beat_pkg::dram_data_t beat;
        for (int idx = 0; idx < 2; idx++)
        begin
            if (mem_model.exists(addr))
            begin
                beat = (idx == 0) ? mem_model[addr][287:144] : mem_model[addr][143:0];
            end
            else
            begin
                beat = ref_beat(addr, idx);
            end
            ret_q.push_back(beat);
            exp_rd.push_back(beat);
        end
    endtask

    task automatic check_command();
        mem_cmd_pkg::addr_entry_t   exp;
        dram_beat_pkg::data_entry_t beat;
        if (exp_cmds.size() == 0)
        begin
            other_cnt++;
            $display("unexpected dram command at address %h", dram_address);
            return;
        end
        exp = exp_cmds[0];
        if (dram_rnw !== exp[0])
            report_mismatch("dram_rnw", exp[0], dram_rnw);
        if (dram_address !== exp[32:1])
            report_mismatch("dram_address", exp[32:1], dram_address);
        if (exp[0])
        begin
            void'(exp_cmds.pop_front());
            queue_read_beats(exp[32:1]);
            return;
        end
        if (beat_model.size() == 0)
        begin
            other_cnt++;
            $display("write beat issued with no beat queued by the client");
            return;
        end
        beat = beat_model.pop_front();
        if (dram_data_o !== beat[161:18])
            report_mismatch("dram_data_o", beat[161:18], dram_data_o);
        if (dram_byte_enable !== beat[17:0])
            report_mismatch("dram_byte_enable", beat[17:0], dram_byte_enable);
        if (!second_beat)
        begin
            first_data  = beat[161:18];
            second_beat = 1'b1;
        end
        else
        begin
            mem_model[exp[32:1]] = {first_data, beat[161:18]};
            second_beat          = 1'b0;
            void'(exp_cmds.pop_front());
        end
    endtask

    always @(posedge Mem_Clk)
    begin
        if (!dram_reset)
        begin
            if (hold_prev && (dram_cmd_en !== 1'b1 ||
                {dram_rnw, dram_address, dram_data_o, dram_byte_enable} !== port_prev))
            begin
                other_cnt++;
                $display("dram outputs changed during a stall at %0t", $time);
            end
            hold_prev = dram_cmd_en && !dram_ready;
            port_prev = {dram_rnw, dram_address, dram_data_o, dram_byte_enable};
            if (dram_cmd_en && dram_ready)
            begin
                check_command();
            end

            // read return side
            if (rd_hold_prev && mem_rd_dout !== rd_prev)
                report_mismatch("mem_rd_dout", rd_prev, mem_rd_dout);
            if (mem_rd_valid && mem_rd_ack)
            begin
                if (exp_rd.size() == 0)
                begin
                    other_cnt++;
                    $display("read beat returned with no read outstanding");
                end
                else
                begin
                    rd_prev = exp_rd.pop_front();
                    if (mem_rd_dout !== rd_prev)
                        report_mismatch("mem_rd_dout", rd_prev, mem_rd_dout);
                    beats_pending--;
                end
            end
            rd_hold_prev = mem_rd_valid && !mem_rd_ack;
            rd_prev      = mem_rd_dout;

            // return beats after a short random gap
            if (ret_delay > 0)
            begin
                ret_delay--;
                dram_data_valid <= 1'b0;
            end
            else if (ret_q.size() > 0)
            begin
                dram_data_valid <= 1'b1;
                dram_data_i     <= ret_q.pop_front();
                ret_delay = {$random(seed)} % 3;
            end
            else
            begin
                dram_data_valid <= 1'b0;
            end
        end
    end

    // ready_mode 0 keeps dram_ready high, 1 randomizes it and 2 holds it low
    always @(posedge Mem_Clk)
    begin
        pace_rnd = $random(seed);
        case (ready_mode)
            0:       dram_ready <= 1'b1;
            1:       dram_ready <= (pace_rnd[2:1] != 2'b00);
            default: dram_ready <= 1'b0;
        endcase
        mem_rd_ack <= ack_random ? pace_rnd[0] : 1'b1;
    end

    // ----------------------------------------
    // client stimulus
    // ----------------------------------------

    task automatic drive_cmd(input logic rnw, input mem_cmd_pkg::mem_addr_t addr,
                             input dram_beat_pkg::dram_data_t din,
                             input dram_beat_pkg::dram_be_t be);
        @(posedge Mem_Clk);
        mem_cmd_valid   <= 1'b1;
        mem_cmd_rnw     <= rnw;
        mem_cmd_address <= addr;
        mem_wr_din      <= din;
        mem_wr_be       <= be;
        // what the intake queues for this command
        if (rnw)
        begin
            pair_open = 1'b0;
            exp_cmds.push_back({addr, 1'b1});
            beats_pending += 2;
        end
        else
        begin
            beat_model.push_back({din, be});
            if (pair_open)
                exp_cmds.push_back({addr, 1'b0});
            pair_open = !pair_open;
        end
        @(posedge Mem_Clk);
        mem_cmd_valid <= 1'b0;
    endtask

    task automatic wait_cmd_room(input logic rnw);
        int n;
        n = 0;
        // the previous command's push shows on mem_cmd_ack one edge later
        @(posedge Mem_Clk);
        while (!(mem_cmd_ack && (!rnw || beats_pending + 2 <= RD_DEPTH)))
        begin
            @(posedge Mem_Clk);
            n++;
            if (n > WAIT_LIMIT)
                abort_run("timeout waiting for mem_cmd_ack or read return room");
        end
    endtask

    task automatic send_cmd(input logic rnw, input mem_cmd_pkg::mem_addr_t addr);
        wait_cmd_room(rnw);
        drive_cmd(rnw, addr, random_beat(), 18'($random(seed)));
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_cmds.size() != 0 || exp_rd.size() != 0 || mem_rd_valid)
        begin
            @(posedge Mem_Clk);
            n++;
            if (n > WAIT_LIMIT)
                abort_run("timeout waiting for queued commands and read data to drain");
        end
    endtask

    task automatic run_random(input int n_ops);
        mem_cmd_pkg::mem_addr_t addr;
        for (int i = 0; i < n_ops; i++)
        begin
            addr = {$random(seed)} & 32'h0000_01f0;
            if ({$random(seed)} % 3 == 0)
            begin
                send_cmd(1'b1, addr);
            end
            else
            begin
                send_cmd(1'b0, addr ^ 32'h40);
                send_cmd(1'b0, addr);
            end
        end
    endtask

    // fill the queues with the dram stalled and predict the ack drop from the pushes
    task automatic fill_test();
        int   addr_cnt;
        int   data_cnt;
        logic predicted;
        wait_drain();
        ready_mode = 2;
        addr_cnt   = 0;
        data_cnt   = beat_model.size();
        for (int i = 0; i <= ADDR_DEPTH; i++)
        begin
            @(posedge Mem_Clk);
            predicted = (ADDR_DEPTH - addr_cnt > AF_MARGIN) &&
                        (DATA_DEPTH - data_cnt > AF_MARGIN);
            if (mem_cmd_ack !== predicted)
                report_mismatch("mem_cmd_ack", predicted, mem_cmd_ack);
            if (!predicted)
                break;
            drive_cmd(1'b0, 32'h0000_0800, random_beat(), 18'($random(seed)));
            drive_cmd(1'b0, 32'h0000_0800 + 32'(i * 16), random_beat(), 18'($random(seed)));
            addr_cnt++;
            data_cnt += 2;
        end
        ready_mode = 1;
        wait_drain();
        @(posedge Mem_Clk);
        if (mem_cmd_ack !== 1'b1)
            report_mismatch("mem_cmd_ack", 1'b1, mem_cmd_ack);
    endtask

    initial
    begin
        seed            = 32'hd1b0a508;
        mismatch_cnt    = 0;
        other_cnt       = 0;
        beats_pending   = 0;
        ready_mode      = 0;
        ret_delay       = 0;
        ack_random      = 1'b0;
        pair_open       = 1'b0;
        second_beat     = 1'b0;
        hold_prev       = 1'b0;
        rd_hold_prev    = 1'b0;
        Mem_Clk         = 1'b0;
        dram_reset      = 1'b1;
        mem_cmd_valid   = 1'b0;
        mem_cmd_rnw     = 1'b0;
        mem_cmd_address = '0;
        mem_wr_din      = '0;
        mem_wr_be       = '0;
        mem_rd_ack      = 1'b0;
        dram_ready      = 1'b0;
        dram_data_valid = 1'b0;
        dram_data_i     = '0;
        repeat (2) @(posedge Mem_Clk);
        dram_reset <= 1'b0;
        @(posedge Mem_Clk);
        if (dram_cmd_en !== 1'b0)
            report_mismatch("dram_cmd_en", 1'b0, dram_cmd_en);
        if (mem_rd_valid !== 1'b0)
            report_mismatch("mem_rd_valid", 1'b0, mem_rd_valid);
        if (mem_cmd_ack !== 1'b1)
            report_mismatch("mem_cmd_ack", 1'b1, mem_cmd_ack);

        // directed write pair, its read back and a read of a fresh address
        send_cmd(1'b0, 32'h0000_1000);
        send_cmd(1'b0, 32'h0000_0100);
        send_cmd(1'b1, 32'h0000_0100);
        send_cmd(1'b1, 32'h0000_0a00);
        wait_drain();

        // stalls on both sides
        ready_mode = 1;
        ack_random = 1'b1;
        run_random(80);
        wait_drain();

        fill_test();

        // lone write broken up by a read
        send_cmd(1'b0, 32'h0000_0300);
        send_cmd(1'b1, 32'h0000_0100);
        send_cmd(1'b0, 32'h0000_0310);
        send_cmd(1'b0, 32'h0000_0320);
        send_cmd(1'b1, 32'h0000_0320);
        ack_random = 1'b0;
        wait_drain();
        repeat (4) @(posedge Mem_Clk);
        finish_run();
    end

endmodule

/* verilog/bridge_fifo.sv */
`timescale 1ns/1ps

module bridge_fifo #(
    parameter int WIDTH     = 8,
    parameter int DEPTH     = 16,
    parameter int AF_MARGIN = 2
) (
    input  logic             Mem_Clk,
    input  logic             dram_reset,
    input  logic             push,
    input  logic [WIDTH-1:0] din,
    input  logic             pop,
    output logic [WIDTH-1:0] dout,
    output logic             empty,
    output logic             almost_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    // wrap at DEPTH, depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty       = (count == '0);
    assign full        = (count == CNT_W'(DEPTH));
    assign almost_full = (DEPTH - int'(count)) <= AF_MARGIN;

    // overflow and underflow are dropped here
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // first word fall through
    assign dout = mem[rd_ptr];

    // ----------------------------------------
    // storage
    // ----------------------------------------

    always_ff @(posedge Mem_Clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= din;
        end
    end

    // ----------------------------------------
    // pointers and occupancy
    // ----------------------------------------

    always_ff @(posedge Mem_Clk)
    begin
        if (dram_reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* verilog/cmd_intake.sv */
`timescale 1ns/1ps

module cmd_intake #(
    parameter int ADDR_DEPTH = 16,
    parameter int DATA_DEPTH = 32,
    parameter int AF_MARGIN  = 2
) (
    input  logic                       Mem_Clk,
    input  logic                       dram_reset,
    input  logic                       mem_cmd_valid,
    input  logic                       mem_cmd_rnw,
    input  mem_cmd_pkg::mem_addr_t     mem_cmd_address,
    input  dram_beat_pkg::dram_data_t  mem_wr_din,
    input  dram_beat_pkg::dram_be_t    mem_wr_be,
    output logic                       mem_cmd_ack,
    output mem_cmd_pkg::addr_entry_t   addr_head,
    output logic                       addr_empty,
    input  logic                       addr_pop,
    output dram_beat_pkg::data_entry_t data_head,
    output logic                       data_empty,
    input  logic                       data_pop
);

    mem_cmd_pkg::addr_entry_t   addr_entry;
    dram_beat_pkg::data_entry_t data_entry;
    logic                       addr_push;
    logic                       data_push;
    logic                       addr_af;
    logic                       data_af;

    // high after the first write of a pair
    logic                       second_half;

    // ----------------------------------------
    // write pairing
    // ----------------------------------------

    always_ff @(posedge Mem_Clk)
    begin
        if (dram_reset)
        begin
            second_half <= 1'b0;
        end
        else if (mem_cmd_valid)
        begin
            // a read breaks up any half-built pair
            if (mem_cmd_rnw)
            begin
                second_half <= 1'b0;
            end
            else
            begin
                second_half <= ~second_half;
            end
        end
    end

    // every write beat is queued, address only once the pair is complete
    assign data_push = mem_cmd_valid & ~mem_cmd_rnw;
    assign addr_push = mem_cmd_valid & (mem_cmd_rnw | second_half);

    assign addr_entry = {mem_cmd_address, mem_cmd_rnw};
    assign data_entry = {mem_wr_din, mem_wr_be};

    // room left in both queues
    assign mem_cmd_ack = ~addr_af & ~data_af;

    // ----------------------------------------
    // queues
    // ----------------------------------------

    bridge_fifo #(
        .WIDTH     ($bits(mem_cmd_pkg::addr_entry_t)),
        .DEPTH     (ADDR_DEPTH),
        .AF_MARGIN (AF_MARGIN)
    ) u_addr_fifo (
        .Mem_Clk     (Mem_Clk),
        .dram_reset  (dram_reset),
        .push        (addr_push),
        .din         (addr_entry),
        .pop         (addr_pop),
        .dout        (addr_head),
        .empty       (addr_empty),
        .almost_full (addr_af)
    );

    bridge_fifo #(
        .WIDTH     ($bits(dram_beat_pkg::data_entry_t)),
        .DEPTH     (DATA_DEPTH),
        .AF_MARGIN (AF_MARGIN)
    ) u_data_fifo (
        .Mem_Clk     (Mem_Clk),
        .dram_reset  (dram_reset),
        .push        (data_push),
        .din         (data_entry),
        .pop         (data_pop),
        .dout        (data_head),
        .empty       (data_empty),
        .almost_full (data_af)
    );

endmodule

/* verilog/dram_beat_pkg.sv */
package dram_beat_pkg;

    // ----------------------------------------
    // dram beat widths
    // ----------------------------------------

    // one beat of the native dram port
    localparam int DRAM_DATA_W = 144;

    // one enable per byte of the beat
    localparam int DRAM_BE_W = DRAM_DATA_W / 8;

    // beat and enables side by side, beat on top
    localparam int DATA_ENTRY_W = DRAM_DATA_W + DRAM_BE_W;

    // ----------------------------------------
    // types
    // ----------------------------------------

    typedef logic [DRAM_DATA_W-1:0] dram_data_t;

    typedef logic [DRAM_BE_W-1:0] dram_be_t;

    // {beat, byte enables}
    typedef logic [DATA_ENTRY_W-1:0] data_entry_t;

endpackage

/* verilog/dram_bridge_top.sv */
`timescale 1ns/1ps

module dram_bridge_top #(
    parameter int ADDR_DEPTH = 16,
    parameter int DATA_DEPTH = 32,
    parameter int RD_DEPTH   = 16,
    parameter int AF_MARGIN  = 2
) (
    input  logic                      Mem_Clk,
    input  logic                      dram_reset,

    // client command side
    input  logic                      mem_cmd_valid,
    input  logic                      mem_cmd_rnw,
    input  mem_cmd_pkg::mem_addr_t    mem_cmd_address,
    input  dram_beat_pkg::dram_data_t mem_wr_din,
    input  dram_beat_pkg::dram_be_t   mem_wr_be,
    output logic                      mem_cmd_ack,

    // client read return
    output logic                      mem_rd_valid,
    output dram_beat_pkg::dram_data_t mem_rd_dout,
    input  logic                      mem_rd_ack,

    // dram native port
    output logic                      dram_cmd_en,
    output logic                      dram_rnw,
    output mem_cmd_pkg::mem_addr_t    dram_address,
    output dram_beat_pkg::dram_data_t dram_data_o,
    output dram_beat_pkg::dram_be_t   dram_byte_enable,
    input  logic                      dram_ready,
    input  logic                      dram_data_valid,
    input  dram_beat_pkg::dram_data_t dram_data_i
);

    mem_cmd_pkg::addr_entry_t   addr_head;
    logic                       addr_empty;
    logic                       addr_pop;
    dram_beat_pkg::data_entry_t data_head;
    logic                       data_empty;
    logic                       data_pop;

    // ----------------------------------------
    // command path
    // ----------------------------------------

    cmd_intake #(
        .ADDR_DEPTH (ADDR_DEPTH),
        .DATA_DEPTH (DATA_DEPTH),
        .AF_MARGIN  (AF_MARGIN)
    ) u_cmd_intake (
        .Mem_Clk         (Mem_Clk),
        .dram_reset      (dram_reset),
        .mem_cmd_valid   (mem_cmd_valid),
        .mem_cmd_rnw     (mem_cmd_rnw),
        .mem_cmd_address (mem_cmd_address),
        .mem_wr_din      (mem_wr_din),
        .mem_wr_be       (mem_wr_be),
        .mem_cmd_ack     (mem_cmd_ack),
        .addr_head       (addr_head),
        .addr_empty      (addr_empty),
        .addr_pop        (addr_pop),
        .data_head       (data_head),
        .data_empty      (data_empty),
        .data_pop        (data_pop)
    );

    dram_issue u_dram_issue (
        .Mem_Clk          (Mem_Clk),
        .dram_reset       (dram_reset),
        .addr_head        (addr_head),
        .addr_empty       (addr_empty),
        .addr_pop         (addr_pop),
        .data_head        (data_head),
        .data_empty       (data_empty),
        .data_pop         (data_pop),
        .dram_ready       (dram_ready),
        .dram_cmd_en      (dram_cmd_en),
        .dram_rnw         (dram_rnw),
        .dram_address     (dram_address),
        .dram_data_o      (dram_data_o),
        .dram_byte_enable (dram_byte_enable)
    );

    // ----------------------------------------
    // read data path
    // ----------------------------------------

    read_return #(
        .RD_DEPTH (RD_DEPTH)
    ) u_read_return (
        .Mem_Clk         (Mem_Clk),
        .dram_reset      (dram_reset),
        .dram_data_valid (dram_data_valid),
        .dram_data_i     (dram_data_i),
        .mem_rd_ack      (mem_rd_ack),
        .mem_rd_valid    (mem_rd_valid),
        .mem_rd_dout     (mem_rd_dout)
    );

endmodule

/* verilog/dram_issue.sv */
`timescale 1ns/1ps

module dram_issue (
    input  logic                       Mem_Clk,
    input  logic                       dram_reset,
    input  mem_cmd_pkg::addr_entry_t   addr_head,
    input  logic                       addr_empty,
    output logic                       addr_pop,
    input  dram_beat_pkg::data_entry_t data_head,
    input  logic                       data_empty,
    output logic                       data_pop,
    input  logic                       dram_ready,
    output logic                       dram_cmd_en,
    output logic                       dram_rnw,
    output mem_cmd_pkg::mem_addr_t     dram_address,
    output dram_beat_pkg::dram_data_t  dram_data_o,
    output dram_beat_pkg::dram_be_t    dram_byte_enable
);

    typedef enum logic {
        ISSUE_FIRST,
        ISSUE_SECOND
    } issue_state_t;

    issue_state_t state;
    issue_state_t state_next;
    logic         head_rnw;
    logic         head_ready;

    // queue heads drive the port directly, so a stall holds everything
    assign head_rnw         = addr_head[0];
    assign dram_rnw         = head_rnw;
    assign dram_address     = addr_head[mem_cmd_pkg::ADDR_ENTRY_W-1:1];
    assign dram_data_o      = data_head[dram_beat_pkg::DATA_ENTRY_W-1:dram_beat_pkg::DRAM_BE_W];
    assign dram_byte_enable = data_head[dram_beat_pkg::DRAM_BE_W-1:0];

    // a write also needs its first beat at the data head
    assign head_ready = ~addr_empty & (head_rnw | ~data_empty);

    // ----------------------------------------
    // issue FSM
    // ----------------------------------------

    always_comb
    begin
        state_next  = state;
        dram_cmd_en = 1'b0;
        addr_pop    = 1'b0;
        data_pop    = 1'b0;
        case (state)
            ISSUE_FIRST:
            begin
                dram_cmd_en = head_ready;
                if (head_ready && dram_ready)
                begin
                    if (head_rnw)
                    begin
                        addr_pop = 1'b1;
                    end
                    else
                    begin
                        // first beat gone, address stays for the second cycle
                        data_pop   = 1'b1;
                        state_next = ISSUE_SECOND;
                    end
                end
            end
            ISSUE_SECOND:
            begin
                // second beat is held until the controller takes it
                dram_cmd_en = 1'b1;
                if (dram_ready)
                begin
                    addr_pop   = 1'b1;
                    data_pop   = 1'b1;
                    state_next = ISSUE_FIRST;
                end
            end
            default: state_next = ISSUE_FIRST;
        endcase
    end

    always_ff @(posedge Mem_Clk)
    begin
        if (dram_reset)
        begin
            state <= ISSUE_FIRST;
        end
        else
        begin
            state <= state_next;
        end
    end

endmodule

/* verilog/mem_cmd_pkg.sv */
package mem_cmd_pkg;

    // ----------------------------------------
    // client command widths
    // ----------------------------------------

    // byte address, same on client and dram side
    localparam int MEM_ADDR_W = 32;

    // address plus read-not-write flag in bit 0
    localparam int ADDR_ENTRY_W = MEM_ADDR_W + 1;

    // ----------------------------------------
    // types
    // ----------------------------------------

    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

    // {address, rnw}
    typedef logic [ADDR_ENTRY_W-1:0] addr_entry_t;

endpackage

/* verilog/read_return.sv */
`timescale 1ns/1ps

module read_return #(
    parameter int RD_DEPTH = 16
) (
    input  logic                      Mem_Clk,
    input  logic                      dram_reset,
    input  logic                      dram_data_valid,
    input  dram_beat_pkg::dram_data_t dram_data_i,
    input  logic                      mem_rd_ack,
    output logic                      mem_rd_valid,
    output dram_beat_pkg::dram_data_t mem_rd_dout
);

    logic rd_empty;
    logic rd_pop;

    // ack without data is ignored
    assign rd_pop       = mem_rd_ack & ~rd_empty;
    assign mem_rd_valid = ~rd_empty;

    // ----------------------------------------
    // return queue
    // ----------------------------------------

    // no back-pressure to the dram, depth bounds outstanding reads
    bridge_fifo #(
        .WIDTH ($bits(dram_beat_pkg::dram_data_t)),
        .DEPTH (RD_DEPTH)
    ) u_rd_fifo (
        .Mem_Clk     (Mem_Clk),
        .dram_reset  (dram_reset),
        .push        (dram_data_valid),
        .din         (dram_data_i),
        .pop         (rd_pop),
        .dout        (mem_rd_dout),
        .empty       (rd_empty),
        .almost_full ()
    );

endmodule
